// ==== common/laa_pkg.sv ====
// Shared types and address map for the linear-algebra accelerator
package laa_pkg;

    // Host opcodes, driven on every cycle by the host
    typedef enum logic [1:0] {
        NONE     = 2'd0, // Idle bus
        READ     = 2'd1, // Read has no side effects
        WRITE    = 2'd2, // Store data_in at addr when idle
        MULTIPLY = 2'd3  // Start C = A*B, then A <= C
    } laa_opcode_e;

    localparam int ADDR_W = 5;  // Register port address width
    localparam int WORD_W = 32; // Word width carried by the request
    localparam int N_ELEM = 9;  // Elements per 3x3 matrix

    // Address map, row-major within each matrix
    localparam logic [ADDR_W-1:0] A_BASE    = 5'd0;  // A at 0..8
    localparam logic [ADDR_W-1:0] B_BASE    = 5'd9;  // B at 9..17
    localparam logic [ADDR_W-1:0] C_BASE    = 5'd18; // C at 18..26, read only
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 5'd31; // Ready flag

    // One host request per cycle
    typedef struct packed {
        laa_opcode_e       opcode;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data_in; // Write data
    } laa_req_t;

    // Full matrix at the request word width
    // Element k sits at row k/3, column k%3
    typedef logic [N_ELEM-1:0][WORD_W-1:0] laa_matrix_t;

endpackage

// ==== laa/matrix_multiplier.sv ====
`timescale 1ns/1ps

// Dot product of one row of A with one column of B
// Element index k selects row k/3 and column k%3
// Purely combinational, the result is valid in the same cycle
module matrix_multiplier #(
    parameter int DATA_W = 32
) (
    input  logic [laa_pkg::N_ELEM-1:0][DATA_W-1:0] a,     // A, row-major
    input  logic [laa_pkg::N_ELEM-1:0][DATA_W-1:0] b,     // B, row-major
    input  logic [3:0]                             stage, // Element index 0..8
    output logic [DATA_W-1:0]                      dot    // Wrapped dot product
);

    localparam int DIM = 3; // Rows and columns per matrix

    logic [1:0] row; // Row of A
    logic [1:0] col; // Column of B

    logic [3:0]        a_idx [DIM]; // Flat index into A per term
    logic [3:0]        b_idx [DIM]; // Flat index into B per term
    logic [DATA_W-1:0] a_sel [DIM];
    logic [DATA_W-1:0] b_sel [DIM];
    logic [DATA_W-1:0] prod  [DIM]; // Low DATA_W bits of each product

    // Element index to row and column
    // A small table is cheaper than a divider for nine values
    always_comb begin
        row = 2'd0;
        col = 2'd0;
        case (stage)
            4'd0: begin
                row = 2'd0;
                col = 2'd0;
            end
            4'd1: begin
                row = 2'd0;
                col = 2'd1;
            end
            4'd2: begin
                row = 2'd0;
                col = 2'd2;
            end
            4'd3: begin
                row = 2'd1;
                col = 2'd0;
            end
            4'd4: begin
                row = 2'd1;
                col = 2'd1;
            end
            4'd5: begin
                row = 2'd1;
                col = 2'd2;
            end
            4'd6: begin
                row = 2'd2;
                col = 2'd0;
            end
            4'd7: begin
                row = 2'd2;
                col = 2'd1;
            end
            4'd8: begin
                row = 2'd2;
                col = 2'd2;
            end
            default: begin // Unused indices fall back to element 0
                row = 2'd0;
                col = 2'd0;
            end
        endcase
    end

    // One term per position along the row of A and the column of B
    for (genvar t = 0; t < DIM; t++) begin : g_term
        assign a_idx[t] = 4'(DIM * row + t); // A[row][t]
        assign b_idx[t] = 4'(DIM * t + col); // B[t][col]

        assign a_sel[t] = a[a_idx[t]];
        assign b_sel[t] = b[b_idx[t]];

        // Assignment width keeps the low DATA_W bits
        assign prod[t] = a_sel[t] * b_sel[t];
    end

    // Sum wraps modulo 2^DATA_W
    assign dot = prod[0] + prod[1] + prod[2];

endmodule

// ==== laa/laa.sv ====
`timescale 1ns/1ps

// Register bank and multiply sequencer
// Bank holds A, B and scratch C, 27 words in all
// A multiply takes nine edges, one C element per edge,
// and the last edge copies C into A
module laa #(
    parameter int DATA_W = 32
) (
    input  logic              bus,      // Clock
    input  logic              arst_n,   // Async reset, active low
    input  laa_pkg::laa_req_t req,      // Host request
    output logic [DATA_W-1:0] data_out  // Combinational read data
);

    // Last element index of a multiply
    localparam logic [3:0] LAST_STAGE = 4'(laa_pkg::N_ELEM - 1);

    // First address past C
    localparam logic [laa_pkg::ADDR_W-1:0] C_END =
        laa_pkg::C_BASE + laa_pkg::ADDR_W'(laa_pkg::N_ELEM);

    // Matrix storage, element k of each matrix at index k
    logic [laa_pkg::N_ELEM-1:0][DATA_W-1:0] mat_a;
    logic [laa_pkg::N_ELEM-1:0][DATA_W-1:0] mat_b;
    logic [laa_pkg::N_ELEM-1:0][DATA_W-1:0] mat_c;

    logic [3:0] stage; // Element under computation, 0 when idle

    logic ready; // Idle, accepts WRITE and MULTIPLY
    logic start; // MULTIPLY accepted this edge
    logic run;   // Storing a C element this edge
    logic last;  // Final element, write-back to A

    // Address decode
    logic       in_a;     // addr in A
    logic       in_b;     // addr in B
    logic       in_c;     // addr in C
    logic       is_ctrl;  // addr is the ready register
    logic [3:0] elem_idx; // Element index within the addressed matrix
    logic       wr_en;

    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] dot; // Dot product for the current stage

    // Sequencer control
    assign ready = (stage == 4'd0);
    assign start = ready && (req.opcode == laa_pkg::MULTIPLY);
    assign run   = start || !ready; // Busy stages and the starting edge
    assign last  = (stage == LAST_STAGE);

    // Region decode, addresses are compared in order of the map
    assign in_a    = (req.addr < laa_pkg::B_BASE);
    assign in_b    = !in_a && (req.addr < laa_pkg::C_BASE);
    assign in_c    = (req.addr >= laa_pkg::C_BASE) && (req.addr < C_END);
    assign is_ctrl = (req.addr == laa_pkg::CTRL_ADDR);

    // Offset of addr from the base of its matrix
    always_comb begin
        if (in_a) begin
            elem_idx = 4'(req.addr - laa_pkg::A_BASE);
        end else if (in_b) begin
            elem_idx = 4'(req.addr - laa_pkg::B_BASE);
        end else begin
            elem_idx = 4'(req.addr - laa_pkg::C_BASE); // Only used when in_c
        end
    end

    // Host writes reach A and B only, and only while idle
    assign wr_en   = ready && (req.opcode == laa_pkg::WRITE) && (in_a || in_b);
    assign wr_data = DATA_W'(req.data_in); // Request carries a fixed word

    // Stage counter
    always_ff @(posedge bus or negedge arst_n) begin
        if (!arst_n) begin
            stage <= 4'd0;
        end else if (run) begin
            stage <= last ? 4'd0 : stage + 4'd1; // Wrap to idle after element 8
        end
    end

    // C collects one element per edge of a multiply
    always_ff @(posedge bus or negedge arst_n) begin
        if (!arst_n) begin
            mat_c <= '0;
        end else if (run) begin
            mat_c[stage] <= dot;
        end
    end

    // A takes host writes, or the finished product on the last edge
    always_ff @(posedge bus or negedge arst_n) begin
        if (!arst_n) begin
            mat_a <= '0;
        end else if (last) begin
            // Elements 0..7 come from C, element 8 is still on dot
            mat_a <= {dot, mat_c[LAST_STAGE-4'd1:0]};
        end else if (wr_en && in_a) begin
            mat_a[elem_idx] <= wr_data;
        end
    end

    // B changes only through host writes
    always_ff @(posedge bus or negedge arst_n) begin
        if (!arst_n) begin
            mat_b <= '0;
        end else if (wr_en && in_b) begin
            mat_b[elem_idx] <= wr_data;
        end
    end

    // Read mux, same cycle as the address
    always_comb begin
        data_out = '0; // Unmapped addresses 27..30
        if (is_ctrl) begin
            data_out = {{(DATA_W-1){1'b0}}, ready};
        end else if (in_a) begin
            data_out = mat_a[elem_idx];
        end else if (in_b) begin
            data_out = mat_b[elem_idx];
        end else if (in_c) begin
            data_out = mat_c[elem_idx];
        end
    end

    // Dot product of row stage/3 of A and column stage%3 of B
    matrix_multiplier #(
        .DATA_W(DATA_W)
    ) u_matrix_multiplier (
        .a    (mat_a),
        .b    (mat_b),
        .stage(stage),
        .dot  (dot)
    );

endmodule

// ==== rtl/laa_top.sv ====
`timescale 1ns/1ps

// Top level of the accelerator
// Host register port on one side, the LAA core below
// Word width is chosen here and passed down the tree
module laa_top #(
    parameter int DATA_W = 32 // Matches the request's data word
) (
    input  logic              bus,      // Clock
    input  logic              arst_n,   // Async reset, active low
    input  laa_pkg::laa_req_t req,      // Opcode, address, write data
    output logic [DATA_W-1:0] data_out  // Read data for req.addr
);

    // Core request and read data
    laa_pkg::laa_req_t core_req;
    logic [DATA_W-1:0] core_data;

    assign core_req = req;
    assign data_out = core_data; // Reads are combinational end to end

    // Register bank, sequencer and multiplier
    laa #(
        .DATA_W(DATA_W)
    ) u_laa (
        .bus     (bus),
        .arst_n  (arst_n),
        .req     (core_req),
        .data_out(core_data)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

// Free-running testbench clock
// Starts low so the first rising edge comes half a period in
module tb_clock #(
    parameter int PERIOD_NS = 40 // Full clock period
) (
    output logic bus // Clock to the DUT and the testbench
);

    localparam int HALF_NS = PERIOD_NS / 2;

    initial begin
        bus = 1'b0;
        forever begin
            #(HALF_NS) bus = ~bus;
        end
    end

endmodule

// ==== verif/laa_tb.sv ====
`timescale 1ns/1ps

// Testbench for laa_top
// Random A and B contents from a fixed seed, checked against a word model
// Inputs change on the falling edge, outputs are sampled 1 ns later
module laa_tb;

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 4;
    localparam int N_WRITES     = 40; // Random A/B writes with read-back
    localparam int N_IGNORED    = 20; // Writes to 18..31
    localparam int N_MULT       = 4;  // Plain multiplies
    localparam int N_BUSY       = 4;  // Multiplies with traffic while busy
    localparam int N_CHAIN      = 3;  // Back-to-back multiplies
    localparam int BUSY_CYCLES  = 8;  // Ready low after the accepting edge
    localparam int MULT_LIMIT   = 20; // Poll limit for one multiply

    // One op is a read, a write or a whole multiply, each under 12 cycles
    localparam int N_OPS = 32 + 2 * N_WRITES + N_IGNORED + 32 + 18
                           + (N_MULT + N_BUSY) * 33 + N_CHAIN + 32;
    localparam int TIMEOUT_NS = (N_OPS * 12 + RESET_CYCLES) * PERIOD_NS;

    logic              bus;
    logic              arst_n;
    laa_pkg::laa_req_t req;
    logic [31:0]       data_out;

    integer seed = 32'hd911_e999;

    logic [31:0] model_mem [27]; // A at 0..8, B at 9..17, C at 18..26
    logic        model_ready;

    tb_clock #(
        .PERIOD_NS(PERIOD_NS)
    ) u_clock (
        .bus(bus)
    );

    laa_top #(
        .DATA_W(32)
    ) DUT (
        .bus     (bus),
        .arst_n  (arst_n),
        .req     (req),
        .data_out(data_out)
    );

    // Ends the run at the first error
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("[FAIL] %s expected %h got %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = 32'($random(seed));
    endfunction

    // Address in lo .. lo+span-1
    function automatic logic [4:0] rand_addr(input int lo, input int span);
        rand_addr = 5'(lo + int'($unsigned($random(seed)) % span));
    endfunction

    // What a read of addr must return, from the address map
    function automatic logic [31:0] expected_read(input logic [4:0] addr);
        if (addr < 5'd27) begin
            expected_read = model_mem[addr];
        end else if (addr == laa_pkg::CTRL_ADDR) begin
            expected_read = {31'd0, model_ready};
        end else begin
            expected_read = 32'd0; // Unmapped 27..30
        end
    endfunction

    // Element (i, j) of A*B, every product and sum wraps at 32 bits
    function automatic logic [31:0] product_elem(input int i, input int j);
        logic [31:0] sum;
        sum = 32'd0;
        for (int k = 0; k < 3; k++) begin
            sum = sum + model_mem[i * 3 + k] * model_mem[9 + k * 3 + j];
        end
        product_elem = sum;
    endfunction

    task automatic write_word(input logic [4:0] addr, input logic [31:0] data);
        @(negedge bus);
        req.opcode  = laa_pkg::WRITE;
        req.addr    = addr;
        req.data_in = data;
        @(posedge bus);
        if (model_ready && addr < laa_pkg::C_BASE) begin
            model_mem[addr] = data; // Only A and B are writable
        end
    endtask

    task automatic read_check(input logic [4:0] addr);
        @(negedge bus);
        req.opcode  = laa_pkg::READ;
        req.addr    = addr;
        req.data_in = 32'd0;
        #1;
        check($sformatf("data_out[addr=%0d]", addr), expected_read(addr), data_out);
    endtask

    // Every address of the map, with no opcode on the bus
    task automatic compare_all();
        for (int a = 0; a < 32; a++) begin
            @(negedge bus);
            req.opcode  = laa_pkg::NONE;
            req.addr    = 5'(a);
            req.data_in = rand_word(); // Ignored without WRITE
            #1;
            check($sformatf("data_out[addr=%0d]", a), expected_read(5'(a)), data_out);
        end
    endtask

    // Issues MULTIPLY and polls the ready register until it returns
    // With busy_ops set, even busy cycles carry a random WRITE or MULTIPLY
    task automatic run_multiply(input bit busy_ops);
        logic [31:0] prod [9];
        logic [4:0]  addr;
        logic [31:0] pick; // Bit 0 chooses WRITE or MULTIPLY
        int          c;
        bit          done;
        for (int k = 0; k < 9; k++) begin
            prod[k] = product_elem(k / 3, k % 3);
        end
        @(negedge bus);
        req.opcode  = laa_pkg::MULTIPLY;
        req.addr    = laa_pkg::CTRL_ADDR;
        req.data_in = rand_word();
        #1;
        check("data_out[ready] before MULTIPLY", 32'd1, data_out);
        @(posedge bus); // Accepting edge
        model_ready = 1'b0;
        c    = 0;
        done = 1'b0;
        while (!done && c < MULT_LIMIT) begin
            @(negedge bus);
            if (busy_ops && c < BUSY_CYCLES && (c % 2) == 0) begin
                addr        = rand_addr(0, 18);
                pick        = rand_word();
                req.opcode  = pick[0] ? laa_pkg::WRITE : laa_pkg::MULTIPLY;
                req.addr    = addr;
                req.data_in = rand_word();
                #1;
                // A holds its old value until the last edge
                check($sformatf("data_out[addr=%0d] while busy", addr), model_mem[addr],
                      data_out);
            end else begin
                req.opcode  = laa_pkg::READ;
                req.addr    = laa_pkg::CTRL_ADDR;
                req.data_in = 32'd0;
                #1;
                if (data_out == 32'd1) begin
                    done = 1'b1;
                end else begin
                    check("data_out[ready] while busy", 32'd0, data_out);
                end
            end
            if (!done) begin
                c++;
            end
        end
        if (!done) begin
            fail_run($sformatf("MULTIPLY did not finish within %0d cycles", MULT_LIMIT));
        end
        check("busy cycle count", 32'(BUSY_CYCLES), 32'(c));
        for (int k = 0; k < 9; k++) begin
            model_mem[k]      = prod[k]; // Product lands in A
            model_mem[18 + k] = prod[k]; // and stays in C
        end
        model_ready = 1'b1;
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        fail_run($sformatf("Watchdog timeout, run exceeded %0d ns", TIMEOUT_NS));
    end

    initial begin
        arst_n      = 1'b0;
        req         = '0;
        model_ready = 1'b1;
        for (int k = 0; k < 27; k++) begin
            model_mem[k] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge bus);
        @(negedge bus);
        arst_n = 1'b1;

        compare_all(); // All zero, ready set

        // Random writes to A and B, each read back
        repeat (N_WRITES) begin
            logic [4:0] addr;
            addr = rand_addr(0, 18);
            write_word(addr, rand_word());
            read_check(addr);
        end

        // C, unmapped and control addresses take no writes
        repeat (N_IGNORED) begin
            write_word(rand_addr(18, 14), rand_word());
        end
        compare_all();

        // Fresh random A and B before the multiplies
        for (int a = 0; a < 18; a++) begin
            write_word(5'(a), rand_word());
        end

        repeat (N_MULT) begin
            run_multiply(1'b0);
            compare_all();
        end

        repeat (N_BUSY) begin
            run_multiply(1'b1);
            compare_all();
        end

        repeat (N_CHAIN) begin
            run_multiply(1'b0); // No reads in between
        end
        compare_all();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/laa_pkg.sv
laa/matrix_multiplier.sv
laa/laa.sv
rtl/laa_top.sv
verif/tb_clock.sv
verif/laa_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the LAA testbench with Verilator
# A $fatal in the simulation gives a nonzero exit status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module laa_tb \
    -f sources.f \
    -o laa_sim \
    && ./obj_dir/laa_sim \
    || { echo "Build or simulation failed"; exit 1; }
